// File: verilog/soc_map_pkg.sv
// ================================================
// SoC memory map
// Device select field, console register offsets
// and the address and data types of the bus
// ================================================
`default_nettype none

package soc_map_pkg;

    // Physical address and data word
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;

    // DRAM is addressed through the low 27 bits only
    typedef logic [26:0] dram_addr_t;

    // Address bits 31..28 pick the target
    typedef enum logic [3:0] {
        DEV_DRAM_LO = 4'h0,
        DEV_CONSOLE = 4'h4,
        DEV_PLIC    = 4'h5,
        DEV_CLINT   = 4'h6,
        DEV_DRAM_HI = 4'h8
    } dev_sel_t;

    // Console device registers
    localparam paddr_t CONS_DATA_OFS  = 32'h0000_0000;
    localparam paddr_t CONS_COUNT_OFS = 32'h0000_0004;
    localparam paddr_t TOHOST_OFS     = 32'h0000_0008;

endpackage

`default_nettype wire

// File: verilog/soc_bus_pkg.sv
// ================================================
// SoC bus definitions
// Load/store sizes, the request bundle shared by
// the arbiter and router, tohost commands
// ================================================
`default_nettype none

package soc_bus_pkg;

    import soc_map_pkg::*;

    // Loads keep their funct3 codes, stores use the free codes
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        SB  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        SH  = 3'b110,
        SW  = 3'b111
    } mem_size_t;

    // One bus request, held stable while it is in flight
    typedef struct packed {
        paddr_t    addr;
        word_t     wdata;
        logic      write;
        mem_size_t size;
    } bus_req_t;

    // DRAM returns whole 16-byte lines
    typedef logic [127:0] dram_line_t;

    // Upper half of a tohost write
    localparam logic [15:0] TOHOST_PRINT     = 16'h0101;
    localparam logic [15:0] TOHOST_POWER_OFF = 16'h0002;

    // Console receive FIFO
    localparam int FIFO_DEPTH = 16;

endpackage

`default_nettype wire

// File: verilog/boot_arbiter.sv
// ================================================
// Boot arbiter
// Streams the kernel image and device tree into
// DRAM, then hands the target bus to the CPU
// ================================================
`default_nettype none

module boot_arbiter
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
#(
    parameter int     IMAGE_WORDS = 24,
    parameter int     DTB_WORDS   = 8,
    parameter paddr_t DTB_BASE    = 32'h0000_0100
) (
    input  wire logic     CLK,
    input  wire logic     rst_n,
    input  wire logic     psel,
    input  wire logic     penable,
    input  wire bus_req_t cpu_req,
    input  wire logic     loader_we,
    input  wire word_t    loader_data,
    input  wire logic     dram_busy,
    input  wire logic     grant_done,
    output logic          pready,
    output logic          loader_ready,
    output logic          init_done,
    output bus_req_t      grant_req,
    output logic          grant_valid,
    output logic          grant_is_boot
);

    typedef enum logic [1:0] {
        BOOT_IMAGE,
        BOOT_DTB,
        BOOT_DONE
    } boot_state_t;

    boot_state_t state;
    paddr_t      img_addr;
    paddr_t      dtb_addr;
    logic        loader_acc;
    logic        cpu_acc;
    logic        img_last;
    logic        dtb_last;

    assign loader_ready = (state != BOOT_DONE) && !dram_busy;
    assign loader_acc   = loader_we && loader_ready;

    // CPU only gets the bus in the APB access phase after boot
    assign cpu_acc = (state == BOOT_DONE) && psel && penable;

    assign img_last = img_addr == paddr_t'((IMAGE_WORDS - 1) * 4);
    assign dtb_last = dtb_addr == DTB_BASE + paddr_t'((DTB_WORDS - 1) * 4);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state    <= BOOT_IMAGE;
            img_addr <= '0;
            dtb_addr <= DTB_BASE;
        end else if (loader_acc) begin
            case (state)
                BOOT_IMAGE: begin
                    img_addr <= img_addr + 32'd4;
                    if (img_last) begin
                        state <= BOOT_DTB;
                    end
                end
                BOOT_DTB: begin
                    dtb_addr <= dtb_addr + 32'd4;
                    if (dtb_last) begin
                        state <= BOOT_DONE;
                    end
                end
                default: state <= state;
            endcase
        end
    end

    // Loader word becomes a full-word store
    always_comb begin
        grant_req = cpu_req;
        if (loader_acc) begin
            grant_req.addr  = (state == BOOT_IMAGE) ? img_addr : dtb_addr;
            grant_req.wdata = loader_data;
            grant_req.write = 1'b1;
            grant_req.size  = SW;
        end
    end

    assign grant_valid   = loader_acc || cpu_acc;
    assign grant_is_boot = loader_acc;
    assign pready        = cpu_acc && grant_done;
    assign init_done     = (state == BOOT_DONE);

    // Boot ends only on the last device tree word
    a_done_after_last_dtb: assert property (
        @(posedge CLK) disable iff (!rst_n)
        $rose(init_done) |-> $past(loader_acc && state == BOOT_DTB && dtb_last)
    );

    // Request must stay put until the target answers
    a_cpu_req_stable: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (psel && penable && !pready) |=> $stable(cpu_req)
    );

endmodule

`default_nettype wire

// File: verilog/target_router.sv
// ================================================
// Target router
// Address decode, target strobes, DRAM load
// alignment and the read data mux
// ================================================
`default_nettype none

module target_router
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
(
    input  wire logic       CLK,
    input  wire logic       rst_n,
    input  wire bus_req_t   grant_req,
    input  wire logic       grant_valid,
    input  wire logic       grant_is_boot,
    input  wire logic       dram_busy,
    input  wire logic       dram_rvalid,
    input  wire dram_line_t dram_rdata,
    input  wire word_t      plic_rdata,
    input  wire word_t      clint_rdata,
    input  wire word_t      con_rdata,
    output logic            grant_done,
    output word_t           prdata,
    output logic            dram_rd_en,
    output logic            dram_wr_en,
    output dram_addr_t      dram_addr,
    output word_t           dram_wdata,
    output mem_size_t       dram_ctrl,
    output logic            plic_we,
    output logic            plic_re,
    output logic            clint_we,
    output logic            clint_re,
    output word_t           plic_wdata,
    output word_t           clint_wdata,
    output logic            con_req,
    output bus_req_t        con_sel
);

    dev_sel_t   dev;
    logic       is_dram;
    logic       rd_pending;
    logic [3:0] rd_ofs;
    mem_size_t  rd_size;
    dram_line_t line_shift;
    word_t      ld_raw;
    word_t      ld_data;

    assign dev     = dev_sel_t'(grant_req.addr[31:28]);
    assign is_dram = grant_is_boot || dev == DEV_DRAM_LO || dev == DEV_DRAM_HI;

    // DRAM side, held off while busy
    assign dram_addr  = grant_req.addr[26:0];
    assign dram_wdata = grant_req.wdata;
    assign dram_ctrl  = grant_req.size;
    assign dram_wr_en = grant_valid && is_dram && grant_req.write && !dram_busy;
    assign dram_rd_en = grant_valid && is_dram && !grant_req.write
                        && !rd_pending && !dram_busy;

    // Interrupt controllers and console
    assign plic_we     = grant_valid && dev == DEV_PLIC && grant_req.write;
    assign plic_re     = grant_valid && dev == DEV_PLIC && !grant_req.write;
    assign clint_we    = grant_valid && dev == DEV_CLINT && grant_req.write;
    assign clint_re    = grant_valid && dev == DEV_CLINT && !grant_req.write;
    assign plic_wdata  = grant_req.wdata;
    assign clint_wdata = grant_req.wdata;
    assign con_req     = grant_valid && !grant_is_boot && dev == DEV_CONSOLE;
    assign con_sel     = grant_req;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else if (dram_rd_en) begin
            rd_pending <= 1'b1;
        end else if (dram_rvalid) begin
            rd_pending <= 1'b0;
        end
    end

    // Byte offset and size of the outstanding read
    always_ff @(posedge CLK) begin
        if (dram_rd_en) begin
            rd_ofs  <= grant_req.addr[3:0];
            rd_size <= grant_req.size;
        end
    end

    assign line_shift = dram_rdata >> {rd_ofs, 3'b000};
    assign ld_raw     = line_shift[31:0];

    always_comb begin
        case (rd_size)
            LB:      ld_data = {{24{ld_raw[7]}}, ld_raw[7:0]};
            LBU:     ld_data = {24'h0, ld_raw[7:0]};
            LH:      ld_data = {{16{ld_raw[15]}}, ld_raw[15:0]};
            LHU:     ld_data = {16'h0, ld_raw[15:0]};
            default: ld_data = ld_raw;
        endcase
    end

    always_comb begin
        case (dev)
            DEV_DRAM_LO, DEV_DRAM_HI: prdata = ld_data;
            DEV_PLIC:                 prdata = plic_rdata;
            DEV_CLINT:                prdata = clint_rdata;
            DEV_CONSOLE:              prdata = con_rdata;
            default:                  prdata = '0;
        endcase
    end

    // Writes finish on issue, reads on return data, MMIO at once
    always_comb begin
        grant_done = 1'b0;
        if (grant_valid) begin
            if (!is_dram) begin
                grant_done = 1'b1;
            end else if (grant_req.write) begin
                grant_done = dram_wr_en;
            end else begin
                grant_done = rd_pending && dram_rvalid;
            end
        end
    end

    // DRAM returns data only for a read that was issued
    a_rvalid_when_pending: assert property (
        @(posedge CLK) disable iff (!rst_n)
        dram_rvalid |-> rd_pending
    );

endmodule

`default_nettype wire

// File: verilog/console_tohost.sv
// ================================================
// Console and tohost
// Receive byte FIFO read through MMIO, tohost
// register for character output and power off
// ================================================
`default_nettype none

module console_tohost
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
(
    input  wire logic       CLK,
    input  wire logic       rst_n,
    input  wire logic       con_req,
    input  wire bus_req_t   con_sel,
    input  wire logic       rx_valid,
    input  wire logic [7:0] rx_data,
    output word_t           con_rdata,
    output logic            char_valid,
    output logic [7:0]      char_data,
    output logic            finish
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [7:0]       fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;
    paddr_t           ofs;
    logic             push;
    logic             pop;
    logic             tohost_we;
    logic [15:0]      tohost_cmd;

    assign ofs = {4'h0, con_sel.addr[27:0]};

    // Bytes arriving on a full FIFO are lost
    assign push = rx_valid && (count < (PTR_W + 1)'(FIFO_DEPTH));
    assign pop  = con_req && !con_sel.write && ofs == CONS_DATA_OFS && count != '0;

    always_ff @(posedge CLK) begin
        if (push) begin
            fifo_mem[tail] <= rx_data;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_comb begin
        con_rdata = '0;
        if (ofs == CONS_DATA_OFS && count != '0) begin
            con_rdata = {24'h0, fifo_mem[head]};
        end else if (ofs == CONS_COUNT_OFS) begin
            con_rdata = word_t'(count);
        end
    end

    // Command sits in the upper half of the written word
    assign tohost_we  = con_req && con_sel.write && ofs == TOHOST_OFS;
    assign tohost_cmd = con_sel.wdata[31:16];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            char_valid <= 1'b0;
            finish     <= 1'b0;
        end else begin
            char_valid <= tohost_we && tohost_cmd == TOHOST_PRINT;
            if (tohost_we && tohost_cmd == TOHOST_POWER_OFF) begin
                finish <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (tohost_we && tohost_cmd == TOHOST_PRINT) begin
            char_data <= con_sel.wdata[7:0];
        end
    end

    a_count_bound: assert property (
        @(posedge CLK) disable iff (!rst_n)
        count <= (PTR_W + 1)'(FIFO_DEPTH)
    );

endmodule

`default_nettype wire

// File: verilog/mem_interconnect.sv
// ================================================
// Memory interconnect
// Boot loading into DRAM, CPU APB routing to DRAM,
// PLIC, CLINT and the console block
// ================================================
`default_nettype none

module mem_interconnect
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
#(
    parameter int     IMAGE_WORDS = 24,
    parameter int     DTB_WORDS   = 8,
    parameter paddr_t DTB_BASE    = 32'h0000_0100
) (
    input  wire logic       CLK,
    input  wire logic       rst_n,
    // CPU APB port
    input  wire logic       psel,
    input  wire logic       penable,
    input  wire bus_req_t   cpu_req,
    output logic            pready,
    output word_t           prdata,
    // Loader stream
    input  wire logic       loader_we,
    input  wire word_t      loader_data,
    output logic            loader_ready,
    // DRAM
    output logic            dram_rd_en,
    output logic            dram_wr_en,
    output dram_addr_t      dram_addr,
    output word_t           dram_wdata,
    output mem_size_t       dram_ctrl,
    input  wire logic       dram_busy,
    input  wire logic       dram_rvalid,
    input  wire dram_line_t dram_rdata,
    // PLIC and CLINT
    output logic            plic_we,
    output logic            plic_re,
    output word_t           plic_wdata,
    input  wire word_t      plic_rdata,
    output logic            clint_we,
    output logic            clint_re,
    output word_t           clint_wdata,
    input  wire word_t      clint_rdata,
    // Console
    input  wire logic       rx_valid,
    input  wire logic [7:0] rx_data,
    output logic            char_valid,
    output logic [7:0]      char_data,
    output logic            finish,
    output logic            init_done
);

    bus_req_t grant_req;
    logic     grant_valid;
    logic     grant_is_boot;
    logic     grant_done;
    logic     con_req;
    bus_req_t con_sel;
    word_t    con_rdata;

    boot_arbiter #(
        .IMAGE_WORDS (IMAGE_WORDS),
        .DTB_WORDS   (DTB_WORDS),
        .DTB_BASE    (DTB_BASE)
    ) i_arbiter (
        .CLK, .rst_n, .psel, .penable, .cpu_req, .loader_we, .loader_data,
        .dram_busy, .grant_done, .pready, .loader_ready, .init_done,
        .grant_req, .grant_valid, .grant_is_boot
    );

    target_router i_router (
        .CLK, .rst_n, .grant_req, .grant_valid, .grant_is_boot, .dram_busy,
        .dram_rvalid, .dram_rdata, .plic_rdata, .clint_rdata, .con_rdata,
        .grant_done, .prdata, .dram_rd_en, .dram_wr_en, .dram_addr, .dram_wdata,
        .dram_ctrl, .plic_we, .plic_re, .clint_we, .clint_re, .plic_wdata,
        .clint_wdata, .con_req, .con_sel
    );

    console_tohost i_console (
        .CLK, .rst_n, .con_req, .con_sel, .rx_valid, .rx_data,
        .con_rdata, .char_valid, .char_data, .finish
    );

endmodule

`default_nettype wire

// File: tb/tb_dram_model.sv
// ================================================
// Behavioral DRAM
// 128-bit line store with random busy and a
// variable read latency
// ================================================
`default_nettype none

module tb_dram_model
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
(
    input  wire logic       CLK,
    input  wire logic       rst_n,
    input  wire logic       dram_rd_en,
    input  wire logic       dram_wr_en,
    input  wire dram_addr_t dram_addr,
    input  wire word_t      dram_wdata,
    input  wire mem_size_t  dram_ctrl,
    output logic            dram_busy,
    output logic            dram_rvalid,
    output dram_line_t      dram_rdata
);

    localparam int LINES = 256;

    dram_line_t lines [LINES];
    logic [7:0] rd_line;
    logic       rd_active;
    int         rd_wait;

    // Byte lanes of a store, starting at the byte offset in the line
    task automatic store_bytes(input dram_addr_t a, input word_t d, input mem_size_t s);
        int nbytes;
        nbytes = (s == SB) ? 1 : (s == SH) ? 2 : 4;
        for (int i = 0; i < nbytes; i++) begin
            lines[a[11:4]][(int'(a[3:0]) + i) * 8 +: 8] = d[i * 8 +: 8];
        end
    endtask

    initial begin
        for (int i = 0; i < LINES; i++) begin
            lines[i] = '0;
        end
        dram_busy   = 1'b0;
        dram_rvalid = 1'b0;
        dram_rdata  = '0;
        rd_active   = 1'b0;
        rd_wait     = 0;
        rd_line     = '0;
    end

    // Strobes hold from the drive point up to the next rising edge
    always @(negedge CLK) begin
        if (rst_n && dram_wr_en) begin
            store_bytes(dram_addr, dram_wdata, dram_ctrl);
        end
        if (rst_n && dram_rd_en) begin
            rd_active = 1'b1;
            rd_line   = dram_addr[11:4];
            rd_wait   = $urandom_range(3, 0);
        end
    end

    always @(posedge CLK) begin
        #1;
        dram_busy   = rst_n && ($urandom_range(3, 0) == 0);
        dram_rvalid = 1'b0;
        if (rd_active && rd_wait == 0) begin
            dram_rvalid = 1'b1;
            dram_rdata  = lines[rd_line];
            rd_active   = 1'b0;
        end else if (rd_active) begin
            rd_wait--;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_mem_interconnect.sv
// ================================================
// Memory interconnect testbench
// Boot stream, random DRAM traffic, PLIC/CLINT,
// console FIFO and tohost, checked against a
// byte-level reference model
// ================================================
`default_nettype none

module tb_mem_interconnect
    import soc_map_pkg::*;
    import soc_bus_pkg::*;
();

    localparam int     IMAGE_WORDS = 24;
    localparam int     DTB_WORDS   = 8;
    localparam paddr_t DTB_BASE    = 32'h0000_0100;
    localparam int     BOOT_WORDS  = IMAGE_WORDS + DTB_WORDS;
    localparam int     WAIT_LIMIT  = 5000;
    localparam paddr_t CONS_BASE   = 32'h4000_0000;
    localparam paddr_t PLIC_BASE   = 32'h5000_0000;
    localparam paddr_t CLINT_BASE  = 32'h6000_0000;

    logic       CLK;
    logic       rst_n;
    logic       psel;
    logic       penable;
    bus_req_t   cpu_req;
    logic       pready;
    word_t      prdata;
    logic       loader_we;
    word_t      loader_data;
    logic       loader_ready;
    logic       dram_rd_en;
    logic       dram_wr_en;
    dram_addr_t dram_addr;
    word_t      dram_wdata;
    mem_size_t  dram_ctrl;
    logic       dram_busy;
    logic       dram_rvalid;
    dram_line_t dram_rdata;
    logic       plic_we;
    logic       plic_re;
    word_t      plic_wdata;
    word_t      plic_rdata;
    logic       clint_we;
    logic       clint_re;
    word_t      clint_wdata;
    word_t      clint_rdata;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       char_valid;
    logic [7:0] char_data;
    logic       finish;
    logic       init_done;

    // Reference model and scratch
    logic [7:0] ref_mem [4096];
    logic [7:0] rx_q [$];
    word_t      boot_words [BOOT_WORDS];
    paddr_t     unmapped [3];
    word_t      rd;
    word_t      wd;
    paddr_t     addr;
    mem_size_t  sz;
    logic [3:0] strobes;
    word_t      seen_plic_wdata;
    word_t      seen_clint_wdata;
    logic       char_seen;
    logic [7:0] char_byte;
    logic [7:0] ch;
    int         word_errs;
    int         load_errs;
    int         flag_errs;
    int         n;

    mem_interconnect #(
        .IMAGE_WORDS (IMAGE_WORDS),
        .DTB_WORDS   (DTB_WORDS),
        .DTB_BASE    (DTB_BASE)
    ) i_dut (.*);

    tb_dram_model i_mem (.*);

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    always @(negedge CLK) begin
        if (pready && !init_done) begin
            $display("[ERROR] %0t: pready high while init_done is low", $time);
            flag_errs++;
        end
        if (char_valid) begin
            char_seen = 1'b1;
            char_byte = char_data;
        end
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_size_load(input mem_size_t s, input paddr_t a, input word_t got,
                                   input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s load at %h got %h expected %h",
                     $time, s.name(), a, got, exp);
            load_errs++;
        end
    endtask

    task automatic check_strobes(input logic [3:0] got, input logic [3:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
            flag_errs++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout, no %s within %0d cycles", what, WAIT_LIMIT);
        $display("** FAIL **");
        $finish;
    endtask

    function automatic paddr_t boot_addr(input int idx);
        if (idx < IMAGE_WORDS) begin
            return paddr_t'(idx * 4);
        end
        return DTB_BASE + paddr_t'((idx - IMAGE_WORDS) * 4);
    endfunction

    function automatic void ref_store(input mem_size_t s, input paddr_t a, input word_t d);
        int nbytes;
        nbytes = (s == SB) ? 1 : (s == SH) ? 2 : 4;
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[a[11:0] + 12'(i)] = d[i * 8 +: 8];
        end
    endfunction

    // RISC-V load extension rule on the little-endian byte model
    function automatic word_t expected_load(input mem_size_t s, input paddr_t a);
        logic [11:0] o;
        word_t       w;
        o = a[11:0];
        w = {ref_mem[o + 12'd3], ref_mem[o + 12'd2], ref_mem[o + 12'd1], ref_mem[o]};
        case (s)
            LB:      return {{24{w[7]}}, w[7:0]};
            LBU:     return {24'h0, w[7:0]};
            LH:      return {{16{w[15]}}, w[15:0]};
            LHU:     return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    // Aligned address in a 512-byte window, dev 0 or dev 8, bit 27 random
    function automatic paddr_t random_dram_addr(input mem_size_t s);
        paddr_t a;
        a = paddr_t'($urandom_range(511, 0));
        if (s inside {LH, LHU, SH}) begin
            a[0] = 1'b0;
        end else if (s inside {LW, SW}) begin
            a[1:0] = 2'b00;
        end
        a[27] = 1'($urandom_range(1, 0));
        if ($urandom_range(1, 0) == 1) begin
            a[31:28] = 4'h8;
        end
        return a;
    endfunction

    task automatic apb_access(input bus_req_t req, output word_t data);
        int waited;
        @(posedge CLK);
        #1;
        cpu_req = req;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge CLK);
        #1;
        penable = 1'b1;
        waited  = 0;
        @(negedge CLK);
        while (!pready) begin
            waited++;
            if (waited == WAIT_LIMIT) begin
                stop_on_timeout("pready");
            end
            @(negedge CLK);
        end
        data             = prdata;
        strobes          = {plic_we, plic_re, clint_we, clint_re};
        seen_plic_wdata  = plic_wdata;
        seen_clint_wdata = clint_wdata;
        @(posedge CLK);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic cpu_write(input paddr_t a, input word_t d, input mem_size_t s);
        bus_req_t req;
        word_t    ignored;
        req = '{addr: a, wdata: d, write: 1'b1, size: s};
        apb_access(req, ignored);
    endtask

    task automatic cpu_read(input paddr_t a, input mem_size_t s, output word_t data);
        bus_req_t req;
        req = '{addr: a, wdata: 32'h0, write: 1'b0, size: s};
        apb_access(req, data);
    endtask

    // Loader words at random gaps, each held until loader_ready
    task automatic load_boot_stream();
        int waited;
        for (int i = 0; i < BOOT_WORDS; i++) begin
            repeat ($urandom_range(3, 0)) begin
                @(posedge CLK);
                #1;
            end
            loader_we   = 1'b1;
            loader_data = boot_words[i];
            waited      = 0;
            @(negedge CLK);
            while (!loader_ready) begin
                waited++;
                if (waited == WAIT_LIMIT) begin
                    stop_on_timeout("loader_ready");
                end
                @(negedge CLK);
            end
            @(posedge CLK);
            #1;
            loader_we = 1'b0;
            ref_store(SW, boot_addr(i), boot_words[i]);
        end
    endtask

    task automatic push_rx_byte(input logic [7:0] b);
        @(posedge CLK);
        #1;
        rx_valid = 1'b1;
        rx_data  = b;
        @(posedge CLK);
        #1;
        rx_valid = 1'b0;
        if (rx_q.size() < FIFO_DEPTH) begin
            rx_q.push_back(b);
        end
    endtask

    initial begin
        void'($urandom(93582));
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        cpu_req     = '0;
        loader_we   = 1'b0;
        loader_data = '0;
        plic_rdata  = word_t'($urandom);
        clint_rdata = word_t'($urandom);
        rx_valid    = 1'b0;
        rx_data     = '0;
        word_errs   = 0;
        load_errs   = 0;
        flag_errs   = 0;
        char_seen   = 1'b0;
        char_byte   = '0;
        strobes     = '0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = 8'h00;
        end
        for (int i = 0; i < BOOT_WORDS; i++) begin
            boot_words[i] = word_t'($urandom);
        end
        unmapped = '{32'h1000_0000, 32'h7000_0040, 32'hF000_0FFC};
        repeat (16) @(posedge CLK);
        #1;
        rst_n = 1'b1;

        // Boot, with a CLINT read already waiting in the access phase
        fork
            load_boot_stream();
            begin
                cpu_read(CLINT_BASE | 32'h10, LW, rd);
                check_word(rd, clint_rdata, "CLINT read during boot");
            end
        join
        n = 0;
        while (!init_done) begin
            n++;
            if (n == WAIT_LIMIT) begin
                stop_on_timeout("init_done");
            end
            @(negedge CLK);
        end
        for (int i = 0; i < BOOT_WORDS; i++) begin
            cpu_read(boot_addr(i), LW, rd);
            check_word(rd, boot_words[i], "boot word readback");
        end

        // Random DRAM stores and loads
        for (int i = 0; i < 300; i++) begin
            sz   = mem_size_t'(3'($urandom_range(7, 0)));
            addr = random_dram_addr(sz);
            if (sz inside {SB, SH, SW}) begin
                wd = word_t'($urandom);
                cpu_write(addr, wd, sz);
                ref_store(sz, addr, wd);
            end else begin
                cpu_read(addr, sz, rd);
                check_size_load(sz, addr, rd, expected_load(sz, addr));
            end
        end

        // PLIC and CLINT
        for (int i = 0; i < 8; i++) begin
            wd          = word_t'($urandom);
            plic_rdata  = word_t'($urandom);
            clint_rdata = word_t'($urandom);
            addr        = paddr_t'($urandom_range(255, 0) * 4);
            if ((i % 2) == 1) begin
                cpu_write(PLIC_BASE | addr, wd, SW);
                check_strobes(strobes, 4'b1000, "PLIC write strobes");
                check_word(seen_plic_wdata, wd, "PLIC write data");
                cpu_read(PLIC_BASE | addr, LW, rd);
                check_strobes(strobes, 4'b0100, "PLIC read strobes");
                check_word(rd, plic_rdata, "PLIC read data");
            end else begin
                cpu_write(CLINT_BASE | addr, wd, SW);
                check_strobes(strobes, 4'b0010, "CLINT write strobes");
                check_word(seen_clint_wdata, wd, "CLINT write data");
                cpu_read(CLINT_BASE | addr, LW, rd);
                check_strobes(strobes, 4'b0001, "CLINT read strobes");
                check_word(rd, clint_rdata, "CLINT read data");
            end
        end
        foreach (unmapped[i]) begin
            cpu_read(unmapped[i], LW, rd);
            check_strobes(strobes, 4'b0000, "unmapped read strobes");
            check_word(rd, 32'h0, "unmapped read data");
        end

        // Console FIFO, first round overflows it
        for (int r = 0; r < 2; r++) begin
            n = (r == 0) ? 20 : int'($urandom_range(15, 1));
            for (int k = 0; k < n; k++) begin
                push_rx_byte(8'($urandom));
            end
            cpu_read(CONS_BASE | CONS_COUNT_OFS, LW, rd);
            check_word(rd, word_t'(rx_q.size()), "console count");
            while (rx_q.size() > 0) begin
                ch = rx_q.pop_front();
                cpu_read(CONS_BASE | CONS_DATA_OFS, LW, rd);
                check_word(rd, {24'h0, ch}, "console data");
            end
            cpu_read(CONS_BASE | CONS_DATA_OFS, LW, rd);
            check_word(rd, 32'h0, "empty console read");
        end

        // tohost print, then power off
        for (int i = 0; i < 3; i++) begin
            ch        = 8'($urandom);
            char_seen = 1'b0;
            cpu_write(CONS_BASE | TOHOST_OFS, {TOHOST_PRINT, 8'h00, ch}, SW);
            n = 0;
            while (!char_seen) begin
                n++;
                if (n == WAIT_LIMIT) begin
                    stop_on_timeout("char_valid");
                end
                @(posedge CLK);
            end
            check_word({24'h0, char_byte}, {24'h0, ch}, "tohost character");
        end
        check_strobes({3'b000, finish}, 4'b0000, "finish before power off");
        cpu_write(CONS_BASE | TOHOST_OFS, {TOHOST_POWER_OFF, 16'h0000}, SW);
        n = 0;
        while (!finish) begin
            n++;
            if (n == WAIT_LIMIT) begin
                stop_on_timeout("finish");
            end
            @(negedge CLK);
        end

        $display("Error counts: word %0d, load %0d, flag %0d", word_errs, load_errs, flag_errs);
        if (word_errs + load_errs + flag_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/soc_map_pkg.sv
verilog/soc_bus_pkg.sv
verilog/boot_arbiter.sv
verilog/target_router.sv
verilog/console_tohost.sv
verilog/mem_interconnect.sv
tb/tb_dram_model.sv
tb/tb_mem_interconnect.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_mem_interconnect -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
